// File: lsu_top.f
+incdir+.
rv_isa_pkg.sv
lsu_bus_pkg.sv
lsu_decoder.sv
lsu_align.sv
lsu_bus_timer.sv
lsu_fsm.sv
lsu_top.sv
lsu_top_tb.sv

// File: lsu_top_tb.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top_tb;

    localparam int NUM_REQS   = 400;
    localparam int MEM_WORDS  = 256;
    localparam int RESP_LIMIT = `LSU_BUS_TIMEOUT + 8;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   req_valid;
    lsu_bus_pkg::lsu_req_t  req;
    logic                   busy;
    logic                   resp_valid;
    lsu_bus_pkg::lsu_resp_t resp;
    lsu_bus_pkg::wb_m2s_t   wb;
    logic [`LSU_XLEN-1:0]   wb_dat_in;
    logic                   wb_ack;
    logic                   wb_err;

    // Slave memory and the reference model's own copy
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];

    integer     seed;
    int         ack_delay;
    int         slave_waits;
    logic       slave_active;
    logic [7:0] slave_idx;
    int         fault_seen [5];
    int         load_count;
    int         store_count;

    lsu_top lsu_top_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp       (resp),
        .wb         (wb),
        .wb_dat_in  (wb_dat_in),
        .wb_ack     (wb_ack),
        .wb_err     (wb_err)
    );

    always #10 clk = ~clk;

    // Wishbone classic slave that answers on the falling edge after ack_delay waits
    always @(negedge clk) begin
        wb_ack    = 1'b0;
        wb_err    = 1'b0;
        slave_idx = wb.adr[9:2];
        if (rst || !(wb.cyc && wb.stb)) begin
            slave_active = 1'b0;
        end else begin
            if (!slave_active) begin
                slave_active = 1'b1;
                slave_waits  = ack_delay;
            end
            if (slave_waits > 0) begin
                slave_waits = slave_waits - 1;
            end else if (wb.adr[31:28] == 4'hF) begin
                wb_err = 1'b1;
            end else if (wb.adr[31:28] != 4'hE) begin
                // Region E never answers
                wb_ack    = 1'b1;
                wb_dat_in = mem[slave_idx];
                for (int b = 0; b < 4; b++) begin
                    if (wb.we && wb.sel[b]) begin
                        mem[slave_idx][8*b +: 8] = wb.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic other_error(input string what);
        $display("Failure at %0t: %s", $time, what);
        abort_run();
    endtask

    function automatic logic [31:0] fill_word(input int i);
        logic [7:0] a;
        a = 8'(i);
        return {a, a ^ 8'hA5, a + 8'h3C, ~a};
    endfunction

    // Bytes moved by a load or store and zero for an illegal request
    function automatic int access_bytes(input logic [6:0] opcode, input logic [2:0] funct3);
        if (opcode == rv_isa_pkg::opcode_load) begin
            case (funct3)
                3'b000, 3'b100: return 1;
                3'b001, 3'b101: return 2;
                3'b010:         return 4;
                default:        return 0;
            endcase
        end
        if (opcode == rv_isa_pkg::opcode_store) begin
            case (funct3)
                3'b000:  return 1;
                3'b001:  return 2;
                3'b010:  return 4;
                default: return 0;
            endcase
        end
        return 0;
    endfunction

    function automatic lsu_bus_pkg::fault_t expected_fault(input lsu_bus_pkg::lsu_req_t r,
                                                           input int nbytes);
        if (nbytes == 0) return lsu_bus_pkg::fault_illegal;
        if ((nbytes == 2 && r.addr[0]) || (nbytes == 4 && r.addr[1:0] != 2'b00)) begin
            return lsu_bus_pkg::fault_misaligned;
        end
        if (r.addr[31:28] == 4'hF) return lsu_bus_pkg::fault_bus_err;
        if (r.addr[31:28] == 4'hE) return lsu_bus_pkg::fault_timeout;
        return lsu_bus_pkg::fault_none;
    endfunction

    // LB and LH sign-extend, LBU and LHU zero-extend
    function automatic logic [31:0] expected_load(input lsu_bus_pkg::lsu_req_t r,
                                                  input int nbytes);
        logic [31:0] word;
        word = shadow[r.addr[9:2]] >> (8 * r.addr[1:0]);
        case (nbytes)
            1:       return r.funct3[2] ? {24'h0, word[7:0]} : {{24{word[7]}}, word[7:0]};
            2:       return r.funct3[2] ? {16'h0, word[15:0]} : {{16{word[15]}}, word[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic lsu_bus_pkg::lsu_req_t random_request();
        lsu_bus_pkg::lsu_req_t r;
        int kind;
        int pick;
        int region;
        kind = {$random(seed)} % 16;
        pick = {$random(seed)} % 5;
        if (kind < 7) begin
            r.opcode = rv_isa_pkg::opcode_load;
            r.funct3 = (pick < 3) ? 3'(pick) : 3'(pick + 1);
        end else if (kind < 13) begin
            r.opcode = rv_isa_pkg::opcode_store;
            r.funct3 = 3'(pick % 3);
        end else begin
            r.opcode = 7'($random(seed));
            // Bit 6 set moves it off both memory opcodes
            if (r.opcode == rv_isa_pkg::opcode_load || r.opcode == rv_isa_pkg::opcode_store) begin
                r.opcode[6] = 1'b1;
            end
            r.funct3 = 3'($random(seed));
        end
        // Now and then a width the decoder must reject
        if (kind == 6 || kind == 12) r.funct3 = 3'($random(seed));
        region = {$random(seed)} % 20;
        r.addr = $random(seed);
        r.addr[31:28] = (region == 0) ? 4'hF : (region == 1) ? 4'hE : 4'h0;
        // Only 64 words so that loads hit earlier stores
        r.addr[9:8] = 2'b00;
        if ({$random(seed)} % 4 != 0) begin
            if (r.funct3[1:0] == 2'b10) r.addr[1:0] = 2'b00;
            if (r.funct3[1:0] == 2'b01) r.addr[0] = 1'b0;
        end
        r.wdata = $random(seed);
        return r;
    endfunction

    task automatic check_idle_outputs();
        assert (!wb.cyc) else value_error("wb.cyc", wb.cyc, 1'b0);
        assert (!wb.stb) else value_error("wb.stb", wb.stb, 1'b0);
        assert (!busy) else value_error("busy", busy, 1'b0);
        assert (!resp_valid) else value_error("resp_valid", resp_valid, 1'b0);
    endtask

    task automatic run_request(input lsu_bus_pkg::lsu_req_t r);
        int                   nbytes;
        int                   cycles;
        int                   cyc_cycles;
        lsu_bus_pkg::fault_t  exp_fault;
        logic [31:0]          exp_rdata;
        logic [3:0]           exp_sel;
        logic [31:0]          exp_dat;
        logic                 exp_bus;
        logic                 is_store;
        logic                 cyc_seen;
        lsu_bus_pkg::wb_m2s_t first_wb;

        nbytes    = access_bytes(r.opcode, r.funct3);
        exp_fault = expected_fault(r, nbytes);
        is_store  = (r.opcode == rv_isa_pkg::opcode_store);
        exp_bus   = (exp_fault != lsu_bus_pkg::fault_illegal) &&
                    (exp_fault != lsu_bus_pkg::fault_misaligned);
        exp_sel   = 4'((1 << nbytes) - 1) << r.addr[1:0];
        exp_dat   = r.wdata << (8 * r.addr[1:0]);
        exp_rdata = '0;
        if (exp_fault == lsu_bus_pkg::fault_none && !is_store) begin
            exp_rdata = expected_load(r, nbytes);
        end
        ack_delay = {$random(seed)} % 4;

        assert (!busy) else value_error("busy", busy, 1'b0);
        req       = r;
        req_valid = 1'b1;
        @(negedge clk);
        cycles     = 1;
        cyc_cycles = 0;
        cyc_seen   = 1'b0;
        while (!resp_valid) begin
            assert (busy) else value_error("busy", busy, 1'b1);
            if (exp_bus && cycles == 1) begin
                assert (wb.cyc) else value_error("wb.cyc", wb.cyc, 1'b1);
            end
            if (wb.cyc) begin
                if (!cyc_seen) first_wb = wb;
                cyc_seen = 1'b1;
                cyc_cycles++;
                assert (exp_bus) else other_error("bus cycle opened after a decode fault");
                assert (wb == first_wb) else other_error("Wishbone outputs changed before ack");
                assert (wb.stb) else value_error("wb.stb", wb.stb, 1'b1);
                assert (wb.we == is_store) else value_error("wb.we", wb.we, is_store);
                assert (wb.sel == exp_sel) else value_error("wb.sel", wb.sel, exp_sel);
                assert (wb.adr == {r.addr[31:2], 2'b00})
                    else value_error("wb.adr", wb.adr, {r.addr[31:2], 2'b00});
                if (is_store) begin
                    assert (wb.dat == exp_dat) else value_error("wb.dat", wb.dat, exp_dat);
                end
            end else begin
                assert (!cyc_seen) else other_error("cyc dropped before ack, err or timeout");
            end
            // Requests offered while busy must be ignored
            req_valid = 1'($random(seed));
            req       = random_request();
            @(negedge clk);
            cycles++;
            assert (cycles <= RESP_LIMIT) else other_error("no response within the time limit");
        end

        if (!exp_bus) begin
            assert (cycles == 2) else value_error("response latency", cycles, 2);
        end else if (exp_fault == lsu_bus_pkg::fault_timeout) begin
            // With no answer from the slave cyc lasts at least the wait limit
            assert (cyc_cycles >= `LSU_BUS_TIMEOUT)
                else other_error("timeout reported before the bus wait limit");
        end else begin
            // cyc holds through the slave's waits and the ack or err cycle
            assert (cyc_cycles == ack_delay + 1)
                else value_error("cyc cycles", cyc_cycles, ack_delay + 1);
        end
        assert (busy) else value_error("busy", busy, 1'b1);
        assert (!wb.cyc && !wb.stb) else other_error("cyc or stb high in the response cycle");
        assert (resp.fault == exp_fault)
            else value_error("resp.fault", 32'(resp.fault), 32'(exp_fault));
        assert (resp.rdata == exp_rdata) else value_error("resp.rdata", resp.rdata, exp_rdata);

        if (exp_fault == lsu_bus_pkg::fault_none && is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (exp_sel[b]) shadow[r.addr[9:2]][8*b +: 8] = exp_dat[8*b +: 8];
            end
        end
        fault_seen[int'(exp_fault)]++;
        if (exp_fault == lsu_bus_pkg::fault_none) begin
            if (is_store) store_count++;
            else load_count++;
        end

        // Still busy in the done cycle, so a request offered now is ignored too
        req_valid = 1'($random(seed));
        req       = random_request();
        @(negedge clk);
        req_valid = 1'b0;
        check_idle_outputs();
    endtask

    initial begin : main_sequence
        int gap;
        seed         = 80080;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        wb_dat_in    = '0;
        wb_ack       = 1'b0;
        wb_err       = 1'b0;
        ack_delay    = 0;
        slave_waits  = 0;
        slave_active = 1'b0;
        load_count   = 0;
        store_count  = 0;
        for (int k = 0; k < 5; k++) fault_seen[k] = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = mem[i];
        end

        // Outputs stay low through the 8 reset cycles
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_idle_outputs();
        end
        rst = 1'b0;
        @(negedge clk);
        check_idle_outputs();

        for (int n = 0; n < NUM_REQS; n++) begin
            gap = {$random(seed)} % 3;
            repeat (gap) begin
                @(negedge clk);
                check_idle_outputs();
            end
            run_request(random_request());
        end

        assert (load_count > 0 && store_count > 0)
            else other_error("random stimulus produced no good load or store");
        for (int k = 1; k < 5; k++) begin
            assert (fault_seen[k] > 0) else other_error("a fault code was never exercised");
        end

        $display("%0d loads, %0d stores, faults %0d/%0d/%0d/%0d", load_count, store_count,
                 fault_seen[1], fault_seen[2], fault_seen[3], fault_seen[4]);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  lsu_bus_pkg::lsu_req_t   req,
    output logic                    busy,
    output logic                    resp_valid,
    output lsu_bus_pkg::lsu_resp_t  resp,
    output lsu_bus_pkg::wb_m2s_t    wb,
    input  logic [`LSU_XLEN-1:0]    wb_dat_in,
    input  logic                    wb_ack,
    input  logic                    wb_err
);

    lsu_bus_pkg::lsu_req_t  held_req;
    rv_isa_pkg::mem_ctrl_t  ctrl;
    logic                   misaligned;
    logic [3:0]             sel;
    logic [`LSU_XLEN-1:0]   wdata_lane;
    logic [`LSU_XLEN-1:0]   rdata;
    logic                   bus_open;
    logic                   expired;

    lsu_fsm lsu_fsm_inst (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .ctrl       (ctrl),
        .misaligned (misaligned),
        .sel        (sel),
        .wdata_lane (wdata_lane),
        .rdata      (rdata),
        .wb_ack     (wb_ack),
        .wb_err     (wb_err),
        .expired    (expired),
        .held_req   (held_req),
        .busy       (busy),
        .bus_open   (bus_open),
        .wb         (wb),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    // Decode works on the registered request
    lsu_decoder lsu_decoder_inst (
        .opcode (held_req.opcode),
        .funct3 (held_req.funct3),
        .ctrl   (ctrl)
    );

    lsu_align lsu_align_inst (
        .ctrl       (ctrl),
        .addr       (held_req.addr),
        .wdata      (held_req.wdata),
        .rdata_raw  (wb_dat_in),
        .sel        (sel),
        .wdata_lane (wdata_lane),
        .misaligned (misaligned),
        .rdata      (rdata)
    );

    // Watchdog on the open bus cycle
    lsu_bus_timer lsu_bus_timer_inst (
        .clk     (clk),
        .rst     (rst),
        .run     (bus_open),
        .expired (expired)
    );

endmodule

// File: lsu_fsm.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  lsu_bus_pkg::lsu_req_t   req,
    input  rv_isa_pkg::mem_ctrl_t   ctrl,
    input  logic                    misaligned,
    input  logic [3:0]              sel,
    input  logic [`LSU_XLEN-1:0]    wdata_lane,
    input  logic [`LSU_XLEN-1:0]    rdata,
    input  logic                    wb_ack,
    input  logic                    wb_err,
    input  logic                    expired,
    output lsu_bus_pkg::lsu_req_t   held_req,
    output logic                    busy,
    output logic                    bus_open,
    output lsu_bus_pkg::wb_m2s_t    wb,
    output logic                    resp_valid,
    output lsu_bus_pkg::lsu_resp_t  resp
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_done
    } state_t;

    state_t state;
    logic   accept;
    logic   decode_fault;
    logic   finish;

    assign accept       = req_valid && (state == st_idle);
    assign decode_fault = ctrl.illegal || misaligned;
    // Ends the access state, either no bus cycle at all or the slave answered
    assign finish       = decode_fault || wb_ack || wb_err || expired;

    assign busy       = (state != st_idle);
    assign resp_valid = (state == st_done);

    // Bus cycle spans the whole access state unless decode failed
    assign bus_open = (state == st_access) && ctrl.require_access && !misaligned;

    // All bus fields come from the held request, so they stay put until ack
    always_comb begin
        wb.cyc = bus_open;
        wb.stb = bus_open;
        wb.we  = bus_open && ctrl.write;
        wb.sel = bus_open ? sel : 4'b0000;
        wb.adr = {held_req.addr[`LSU_XLEN-1:2], 2'b00};
        wb.dat = wdata_lane;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_access;
                    end
                end
                st_access: begin
                    if (finish) begin
                        state <= st_done;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_req <= req;
        end
        if (state == st_access) begin
            // Fault priority: illegal, misaligned, err, then timeout
            if (ctrl.illegal) begin
                resp.rdata <= '0;
                resp.fault <= lsu_bus_pkg::fault_illegal;
            end else if (misaligned) begin
                resp.rdata <= '0;
                resp.fault <= lsu_bus_pkg::fault_misaligned;
            end else if (wb_err) begin
                resp.rdata <= '0;
                resp.fault <= lsu_bus_pkg::fault_bus_err;
            end else if (wb_ack) begin
                // Stores return zero data
                resp.rdata <= ctrl.write ? '0 : rdata;
                resp.fault <= lsu_bus_pkg::fault_none;
            end else if (expired) begin
                resp.rdata <= '0;
                resp.fault <= lsu_bus_pkg::fault_timeout;
            end
        end
    end

endmodule

// File: lsu_bus_timer.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_bus_timer (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic expired
);

    localparam int CNT_W = $clog2(`LSU_BUS_TIMEOUT + 1);

    logic [CNT_W-1:0] count;

    // Counts cycles of an open bus cycle, holds once expired
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            count   <= '0;
            expired <= 1'b0;
        end else if (!expired) begin
            count   <= count + 1'b1;
            // Last wait cycle seen, flag from the next cycle on
            expired <= (count == CNT_W'(`LSU_BUS_TIMEOUT - 1));
        end
    end

endmodule

// File: lsu_align.sv
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_align (
    input  rv_isa_pkg::mem_ctrl_t ctrl,
    input  logic [`LSU_XLEN-1:0]  addr,
    input  logic [`LSU_XLEN-1:0]  wdata,
    input  logic [`LSU_XLEN-1:0]  rdata_raw,
    output logic [3:0]            sel,
    output logic [`LSU_XLEN-1:0]  wdata_lane,
    output logic                  misaligned,
    output logic [`LSU_XLEN-1:0]  rdata
);

    logic [1:0]           offset;
    logic [4:0]           shamt;
    logic [`LSU_XLEN-1:0] rdata_shifted;
    logic                 sign_bit;

    // Byte offset inside the word and the matching bit shift
    assign offset = addr[1:0];
    assign shamt  = {offset, 3'b000};

    // Store data moves up to its lane, load data comes down to bit 0
    assign wdata_lane    = wdata << shamt;
    assign rdata_shifted = rdata_raw >> shamt;

    always_comb begin
        case (ctrl.access_size)
            rv_isa_pkg::size_byte: sel = 4'b0001 << offset;
            rv_isa_pkg::size_half: sel = 4'b0011 << offset;
            rv_isa_pkg::size_word: sel = 4'b1111;
            default:               sel = 4'b0000;
        endcase
    end

    // Halves need an even address, words a multiple of four
    always_comb begin
        case (ctrl.access_size)
            rv_isa_pkg::size_half: misaligned = offset[0];
            rv_isa_pkg::size_word: misaligned = |offset;
            default:               misaligned = 1'b0;
        endcase
    end

    // Top bit of the loaded item, forced low for LBU and LHU
    always_comb begin
        case (ctrl.access_size)
            rv_isa_pkg::size_byte: sign_bit = rdata_shifted[7] && !ctrl.zero_extend;
            rv_isa_pkg::size_half: sign_bit = rdata_shifted[15] && !ctrl.zero_extend;
            default:               sign_bit = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.access_size)
            rv_isa_pkg::size_byte: rdata = {{(`LSU_XLEN-8){sign_bit}}, rdata_shifted[7:0]};
            rv_isa_pkg::size_half: rdata = {{(`LSU_XLEN-16){sign_bit}}, rdata_shifted[15:0]};
            rv_isa_pkg::size_word: rdata = rdata_shifted;
            default:               rdata = '0;
        endcase
    end

endmodule

// File: lsu_decoder.sv
`timescale 1ns/1ps

module lsu_decoder (
    input  logic [6:0]            opcode,
    input  logic [2:0]            funct3,
    output rv_isa_pkg::mem_ctrl_t ctrl
);

    logic                     is_load;
    logic                     is_store;
    rv_isa_pkg::access_size_t size;

    assign is_load  = (opcode == rv_isa_pkg::opcode_load);
    assign is_store = (opcode == rv_isa_pkg::opcode_store);

    // Width from funct3, anything unknown stays size_none
    always_comb begin
        size = rv_isa_pkg::size_none;
        if (is_load) begin
            case (funct3)
                rv_isa_pkg::funct3_lb,
                rv_isa_pkg::funct3_lbu: size = rv_isa_pkg::size_byte;
                rv_isa_pkg::funct3_lh,
                rv_isa_pkg::funct3_lhu: size = rv_isa_pkg::size_half;
                rv_isa_pkg::funct3_lw:  size = rv_isa_pkg::size_word;
                default:                size = rv_isa_pkg::size_none;
            endcase
        end else if (is_store) begin
            case (funct3)
                rv_isa_pkg::funct3_sb: size = rv_isa_pkg::size_byte;
                rv_isa_pkg::funct3_sh: size = rv_isa_pkg::size_half;
                rv_isa_pkg::funct3_sw: size = rv_isa_pkg::size_word;
                default:               size = rv_isa_pkg::size_none;
            endcase
        end
    end

    always_comb begin
        ctrl.access_size    = size;
        // Only stores write to memory
        ctrl.write          = is_store;
        ctrl.require_access = (size != rv_isa_pkg::size_none);
        // Unsigned loads have funct3 bit 2 set
        ctrl.zero_extend    = is_load && funct3[2];
        ctrl.illegal        = (size == rv_isa_pkg::size_none);
    end

endmodule

// File: lsu_bus_pkg.sv
`include "lsu_defines.svh"

package lsu_bus_pkg;

    // Request from the core, address already computed upstream
    typedef struct packed {
        logic [6:0]           opcode;
        logic [2:0]           funct3;
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] wdata;
    } lsu_req_t;

    // Fault codes reported with each response
    typedef enum logic [2:0] {
        fault_none       = 3'd0,
        fault_illegal    = 3'd1,
        fault_misaligned = 3'd2,
        fault_bus_err    = 3'd3,
        fault_timeout    = 3'd4
    } fault_t;

    // Response to the core
    typedef struct packed {
        logic [`LSU_XLEN-1:0] rdata;
        fault_t               fault;
    } lsu_resp_t;

    // Wishbone classic master outputs
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`LSU_XLEN/8-1:0] sel;
        logic [`LSU_XLEN-1:0]   adr;
        logic [`LSU_XLEN-1:0]   dat;
    } wb_m2s_t;

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes handled by the load/store unit
    localparam logic [6:0] opcode_load  = 7'b0000011;
    localparam logic [6:0] opcode_store = 7'b0100011;

    // Load widths
    localparam logic [2:0] funct3_lb  = 3'b000;
    localparam logic [2:0] funct3_lh  = 3'b001;
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam logic [2:0] funct3_lbu = 3'b100;
    localparam logic [2:0] funct3_lhu = 3'b101;

    // Store widths
    localparam logic [2:0] funct3_sb = 3'b000;
    localparam logic [2:0] funct3_sh = 3'b001;
    localparam logic [2:0] funct3_sw = 3'b010;

    // Access size, same encoding as the core's old memory controller
    typedef enum logic [1:0] {
        size_word = 2'b00,
        size_half = 2'b01,
        size_byte = 2'b10,
        size_none = 2'b11
    } access_size_t;

    // Decoded memory access controls
    typedef struct packed {
        // Width of the transfer
        access_size_t access_size;
        // Store
        logic         write;
        // Valid load or store, goes to the bus
        logic         require_access;
        // LBU and LHU
        logic         zero_extend;
        // Not a memory instruction or bad width
        logic         illegal;
    } mem_ctrl_t;

endpackage

// File: lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address width
`define LSU_XLEN 32

// Cycles a bus cycle may wait for ack or err
`define LSU_BUS_TIMEOUT 16

`endif
